// ==== hdl/ahbBus_config.svh ====
// Bus subsystem configuration: widths, depths, region codes and fixed words
`ifndef AHB_BUS_CONFIG_SVH
`define AHB_BUS_CONFIG_SVH

// Address and data word width
`define AHB_DATA_W 32

// Local RAM depth in words
`define RAM_WORDS 256

// Replay queue entries, a power of two
`define REPLAY_DEPTH 16

// Region codes taken from address bits 31 to 28
`define RAM_REGION 4'h0
`define IO_REGION 4'h1

// Interrupt register, word offset inside IO space (byte address 0x1000_0400)
`define IRQ_REG_OFS 26'h100

// Read data returned when the replay queue head does not match
`define IO_POISON 32'hDEADBEEF

`endif

// ==== hdl/ahbPkg.sv ====
// Shared bus types, mainly the address word with its two decoded views
`include "ahbBus_config.svh"

package ahbPkg;

    // Decoder view: region code and offset inside the region
    typedef struct packed {
        logic [3:0]               region;
        logic [`AHB_DATA_W-5:0]   offset;
    } ahbRegionView_t;

    // Slave view: word index and byte lane
    typedef struct packed {
        logic [`AHB_DATA_W-3:0]   wordIdx;
        logic [1:0]               lane;
    } ahbWordView_t;

    // One address word, read as either view
    typedef union packed {
        ahbRegionView_t rgn;
        ahbWordView_t   word;
    } ahbAddr_u;

endpackage

// ==== hdl/ahbIf.sv ====
// Per-slave bus connection between the address decoder and one slave
`include "ahbBus_config.svh"

interface ahbIf import ahbPkg::*; ();

    // Address phase, driven by the decoder
    logic                   sel;
    logic                   request;
    ahbAddr_u               addr;
    logic                   write;

    // Data phase
    logic [`AHB_DATA_W-1:0] wdata;
    logic [`AHB_DATA_W-1:0] rdata;
    logic                   ready;

    modport master (
        output sel,
        output request,
        output addr,
        output write,
        output wdata,
        input  rdata,
        input  ready
    );

    modport slave (
        input  sel,
        input  request,
        input  addr,
        input  write,
        input  wdata,
        output rdata,
        output ready
    );

endinterface

// ==== hdl/ahbDecoder.sv ====
// Address decoder that selects a region on the address phase and muxes the return on the data phase
`include "ahbBus_config.svh"

module ahbDecoder import ahbPkg::*; (
    input  logic                   HCLK,
    input  logic                   rst,
    input  logic                   HSEL,
    input  logic                   HREQUEST,
    input  logic                   HWRITE,
    input  logic [`AHB_DATA_W-1:0] HADDR,
    input  logic [`AHB_DATA_W-1:0] HWDATA,
    output logic [`AHB_DATA_W-1:0] HRDATA,
    output logic                   HREADY,
    ahbIf.master                   ramBus,
    ahbIf.master                   ioBus
);

    ahbAddr_u   hAddr;
    logic       dpValid;
    logic [3:0] dpRegion;

    assign hAddr = HADDR;

    // Address phase fan-out where only one slave sees sel
    assign ramBus.sel     = HSEL && (hAddr.rgn.region == `RAM_REGION);
    assign ramBus.request = HREQUEST;
    assign ramBus.addr    = hAddr;
    assign ramBus.write   = HWRITE;
    assign ramBus.wdata   = HWDATA;

    assign ioBus.sel      = HSEL && (hAddr.rgn.region == `IO_REGION);
    assign ioBus.request  = HREQUEST;
    assign ioBus.addr     = hAddr;
    assign ioBus.write    = HWRITE;
    assign ioBus.wdata    = HWDATA;

    // Remember which region owns the next data phase
    always_ff @(posedge HCLK) begin
        if (rst) begin
            dpValid  <= 1'b0;
            dpRegion <= '0;
        end else begin
            dpValid  <= HSEL && HREQUEST;
            dpRegion <= hAddr.rgn.region;
        end
    end

    always_comb begin
        case (dpRegion)
            `RAM_REGION: begin
                HRDATA = ramBus.rdata;
                HREADY = ramBus.ready;
            end
            `IO_REGION: begin
                HRDATA = ioBus.rdata;
                HREADY = ioBus.ready;
            end
            // Unmapped region completes with zero data
            default: begin
                HRDATA = '0;
                HREADY = dpValid;
            end
        endcase
    end

    // The owning slave answers every data phase and no other cycle
    readyOnDataPhase: assert property (@(posedge HCLK) disable iff (rst)
        HREADY == dpValid);

endmodule

// ==== hdl/ahbRam.sv ====
// Local RAM slave that moves one word per transfer in a single data phase
`include "ahbBus_config.svh"

module ahbRam import ahbPkg::*; (
    input  logic HCLK,
    input  logic rst,
    ahbIf.slave  bus
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    logic [`AHB_DATA_W-1:0] mem [`RAM_WORDS];
    logic [IDX_W-1:0]       idx;
    logic [IDX_W-1:0]       wrIdx;
    logic                   wrPend;
    logic                   addrPhase;

    assign addrPhase = bus.sel && bus.request;
    assign idx       = bus.addr.word.wordIdx[IDX_W-1:0];

    always_ff @(posedge HCLK) begin
        if (rst) begin
            bus.ready <= 1'b0;
            wrPend    <= 1'b0;
        end else begin
            bus.ready <= addrPhase;
            wrPend    <= addrPhase && bus.write;
        end
    end

    // Write index is held until the data phase ends
    always_ff @(posedge HCLK) begin
        if (addrPhase) begin
            wrIdx <= idx;
        end
        if (wrPend) begin
            mem[wrIdx] <= bus.wdata;
        end
    end

    always_ff @(posedge HCLK) begin
        if (addrPhase && !bus.write) begin
            // Read right behind a write to the same word sees the new data
            if (wrPend && (wrIdx == idx)) begin
                bus.rdata <= bus.wdata;
            end else begin
                bus.rdata <= mem[idx];
            end
        end
    end

    // Master presents known write data in every write data phase
    wdataKnown: assert property (@(posedge HCLK) disable iff (rst)
        wrPend |-> !$isunknown(bus.wdata));

endmodule

// ==== hdl/ioFwdShim.sv ====
// IO replay slave that answers IO reads from a queue of recorded pairs and drives irq and fiq
`include "ahbBus_config.svh"

module ioFwdShim import ahbPkg::*; (
    input  logic                   HCLK,
    input  logic                   rst,
    ahbIf.slave                    bus,
    input  logic                   pushValid,
    input  logic [`AHB_DATA_W-1:0] pushAddr,
    input  logic [`AHB_DATA_W-1:0] pushData,
    output logic                   irq,
    output logic                   fiq,
    output logic                   replayMiss,
    output logic                   replayFull
);

    localparam int PTR_W = $clog2(`REPLAY_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [`AHB_DATA_W-1:0] qAddr [`REPLAY_DEPTH];
    logic [`AHB_DATA_W-1:0] qVal  [`REPLAY_DEPTH];
    logic [PTR_W-1:0]       head;
    logic [PTR_W-1:0]       tail;
    logic [CNT_W-1:0]       count;

    logic addrPhase;
    logic rdPhase;
    logic hit;
    logic pushAccept;
    logic irqWrPend;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`REPLAY_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign addrPhase  = bus.sel && bus.request;
    assign rdPhase    = addrPhase && !bus.write;
    assign replayFull = (count == CNT_W'(`REPLAY_DEPTH));
    assign pushAccept = pushValid && !replayFull;

    // A read hits only when the head entry was recorded for this address
    assign hit = rdPhase && (count != '0) && (qAddr[head] == bus.addr);

    always_ff @(posedge HCLK) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            bus.ready  <= 1'b0;
            irqWrPend  <= 1'b0;
            replayMiss <= 1'b0;
            irq        <= 1'b0;
            fiq        <= 1'b0;
        end else begin
            bus.ready <= addrPhase;
            irqWrPend <= addrPhase && bus.write &&
                         (bus.addr.word.wordIdx[25:0] == `IRQ_REG_OFS);
            if (pushAccept) begin
                tail <= nextPtr(tail);
            end
            if (hit) begin
                head <= nextPtr(head);
            end
            if (pushAccept && !hit) begin
                count <= count + 1'b1;
            end else if (hit && !pushAccept) begin
                count <= count - 1'b1;
            end
            // Sticky until reset
            if (rdPhase && !hit) begin
                replayMiss <= 1'b1;
            end
            // Interrupt register write takes its data at the end of the data phase
            if (irqWrPend) begin
                irq <= bus.wdata[0];
                fiq <= bus.wdata[1];
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (pushAccept) begin
            qAddr[tail] <= pushAddr;
            qVal[tail]  <= pushData;
        end
    end

    always_ff @(posedge HCLK) begin
        if (rdPhase) begin
            bus.rdata <= hit ? qVal[head] : `IO_POISON;
        end
    end

    // Tail always sits count entries past the head
    ptrConsistent: assert property (@(posedge HCLK) disable iff (rst)
        tail == PTR_W'(head + count));

endmodule

// ==== hdl/ahbSubsys.sv ====
// Bus subsystem top: decoder with RAM and IO replay slaves behind it
`include "ahbBus_config.svh"

module ahbSubsys (
    input  logic                   HCLK,
    input  logic                   rst,
    input  logic                   HSEL,
    input  logic                   HREQUEST,
    input  logic                   HWRITE,
    input  logic [`AHB_DATA_W-1:0] HADDR,
    input  logic [`AHB_DATA_W-1:0] HWDATA,
    input  logic                   pushValid,
    input  logic [`AHB_DATA_W-1:0] pushAddr,
    input  logic [`AHB_DATA_W-1:0] pushData,
    output logic [`AHB_DATA_W-1:0] HRDATA,
    output logic                   HREADY,
    output logic                   irq,
    output logic                   fiq,
    output logic                   replayMiss,
    output logic                   replayFull
);

    ahbIf ramBus ();
    ahbIf ioBus ();

    ahbDecoder decoder_i (
        .HCLK     (HCLK),
        .rst      (rst),
        .HSEL     (HSEL),
        .HREQUEST (HREQUEST),
        .HWRITE   (HWRITE),
        .HADDR    (HADDR),
        .HWDATA   (HWDATA),
        .HRDATA   (HRDATA),
        .HREADY   (HREADY),
        .ramBus   (ramBus.master),
        .ioBus    (ioBus.master)
    );

    ahbRam ram_i (
        .HCLK (HCLK),
        .rst  (rst),
        .bus  (ramBus.slave)
    );

    // Replay queue is loaded through the push port ahead of the reads
    ioFwdShim ioShim_i (
        .HCLK       (HCLK),
        .rst        (rst),
        .bus        (ioBus.slave),
        .pushValid  (pushValid),
        .pushAddr   (pushAddr),
        .pushData   (pushData),
        .irq        (irq),
        .fiq        (fiq),
        .replayMiss (replayMiss),
        .replayFull (replayFull)
    );

endmodule

// ==== tests/ahbSubsysTb.sv ====
// Testbench for the bus subsystem with RAM and IO replay traffic checked by assertions
`include "ahbBus_config.svh"

module ahbSubsysTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int RAM_WRITES    = 16;
    localparam int IRQ_WRITES    = 6;
    localparam int IDX_W         = $clog2(`RAM_WORDS);
    // Address phases and pushes over all tests size the watchdog
    localparam int XFER_COUNT    = RAM_WRITES + RAM_WRITES + 1 + (`REPLAY_DEPTH + 1)
                                 + `REPLAY_DEPTH / 2 + `REPLAY_DEPTH / 2 + 2 + IRQ_WRITES;
    localparam int MARGIN_CYCLES = 60 + RESET_CYCLES;
    localparam logic [`AHB_DATA_W-1:0] IRQ_ADDR =
        {`IO_REGION, 28'h0} | (32'(`IRQ_REG_OFS) << 2);

    logic                   HCLK;
    logic                   rst;
    logic                   HSEL;
    logic                   HREQUEST;
    logic                   HWRITE;
    logic [`AHB_DATA_W-1:0] HADDR;
    logic [`AHB_DATA_W-1:0] HWDATA;
    logic                   pushValid;
    logic [`AHB_DATA_W-1:0] pushAddr;
    logic [`AHB_DATA_W-1:0] pushData;
    logic [`AHB_DATA_W-1:0] HRDATA;
    logic                   HREADY;
    logic                   irq;
    logic                   fiq;
    logic                   replayMiss;
    logic                   replayFull;

    // Reference model state
    logic [`AHB_DATA_W-1:0] ramModel [`RAM_WORDS];
    logic [`AHB_DATA_W-1:0] replayAddrQ [$];
    logic [`AHB_DATA_W-1:0] replayValQ [$];
    logic                   wasFull;
    logic                   dpValid;
    logic                   dpRead;
    logic                   dpWrite;
    logic                   dpIrqWr;
    logic [3:0]             dpRegion;
    logic [IDX_W-1:0]       dpIdx;
    logic [`AHB_DATA_W-1:0] expRdata;
    logic                   expIrq;
    logic                   expFiq;
    logic                   expMiss;
    logic                   expFull;

    logic [`AHB_DATA_W-1:0] nextWdata;
    logic [`AHB_DATA_W-1:0] addrList [$];
    int                     seed = 31;
    int                     failCount = 0;
    int                     failsAtStart = 0;
    int                     testsPassed = 0;
    int                     testsFailed = 0;

    ahbSubsys ahbSubsys_i (
        .HCLK       (HCLK),
        .rst        (rst),
        .HSEL       (HSEL),
        .HREQUEST   (HREQUEST),
        .HWRITE     (HWRITE),
        .HADDR      (HADDR),
        .HWDATA     (HWDATA),
        .pushValid  (pushValid),
        .pushAddr   (pushAddr),
        .pushData   (pushData),
        .HRDATA     (HRDATA),
        .HREADY     (HREADY),
        .irq        (irq),
        .fiq        (fiq),
        .replayMiss (replayMiss),
        .replayFull (replayFull)
    );

    initial begin
        HCLK = 1'b0;
        forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
    end

    // Predict every transfer from the bus rules on each edge
    always @(posedge HCLK) begin
        if (rst) begin
            dpValid <= 1'b0;
            dpRead  <= 1'b0;
            expIrq  <= 1'b0;
            expFiq  <= 1'b0;
            expMiss <= 1'b0;
            expFull <= 1'b0;
            replayAddrQ.delete();
            replayValQ.delete();
        end else begin
            // Data phase ending at this edge stores its write data
            if (dpValid && dpWrite && dpRegion == `RAM_REGION) begin
                ramModel[dpIdx] = HWDATA;
            end
            if (dpValid && dpWrite && dpIrqWr) begin
                expIrq <= HWDATA[0];
                expFiq <= HWDATA[1];
            end
            wasFull = (replayAddrQ.size() == `REPLAY_DEPTH);
            dpValid  <= HSEL && HREQUEST;
            dpRead   <= !HWRITE;
            dpWrite  <= HWRITE;
            dpRegion <= HADDR[31:28];
            dpIdx    <= HADDR[IDX_W+1:2];
            dpIrqWr  <= (HADDR[31:28] == `IO_REGION) && (HADDR[27:2] == `IRQ_REG_OFS);
            if (HSEL && HREQUEST && !HWRITE) begin
                if (HADDR[31:28] == `RAM_REGION) begin
                    expRdata <= ramModel[HADDR[IDX_W+1:2]];
                end else if (HADDR[31:28] == `IO_REGION) begin
                    if (replayAddrQ.size() != 0 && replayAddrQ[0] == HADDR) begin
                        expRdata <= replayValQ.pop_front();
                        void'(replayAddrQ.pop_front());
                    end else begin
                        expRdata <= `IO_POISON;
                        expMiss  <= 1'b1;
                    end
                end else begin
                    expRdata <= '0;
                end
            end
            if (pushValid && !wasFull) begin
                replayAddrQ.push_back(pushAddr);
                replayValQ.push_back(pushData);
            end
            expFull <= (replayAddrQ.size() == `REPLAY_DEPTH);
        end
    end

    resetState: assert property (@(posedge HCLK)
        $fell(rst) |-> !HREADY && !irq && !fiq && !replayMiss && !replayFull)
        else reportFail("outputs not low after reset");

    readyPulse: assert property (@(posedge HCLK) disable iff (rst) HREADY == dpValid)
        else reportFail($sformatf("HREADY %b, expected %b",
            $sampled(HREADY), $sampled(dpValid)));

    readData: assert property (@(posedge HCLK) disable iff (rst)
        (dpValid && dpRead) |-> HRDATA == expRdata)
        else reportFail($sformatf("HRDATA %h, expected %h",
            $sampled(HRDATA), $sampled(expRdata)));

    irqState: assert property (@(posedge HCLK) disable iff (rst)
        {irq, fiq} == {expIrq, expFiq})
        else reportFail($sformatf("irq/fiq %b%b, expected %b%b",
            $sampled(irq), $sampled(fiq), $sampled(expIrq), $sampled(expFiq)));

    missState: assert property (@(posedge HCLK) disable iff (rst) replayMiss == expMiss)
        else reportFail($sformatf("replayMiss %b, expected %b",
            $sampled(replayMiss), $sampled(expMiss)));

    missSticky: assert property (@(posedge HCLK) disable iff (rst) replayMiss |=> replayMiss)
        else reportFail("replayMiss fell without reset");

    fullState: assert property (@(posedge HCLK) disable iff (rst) replayFull == expFull)
        else reportFail($sformatf("replayFull %b, expected %b",
            $sampled(replayFull), $sampled(expFull)));

    task automatic reportFail(input string msg);
        failCount++;
        $display("FAIL %0t ns: %s", $time, msg);
    endtask

    task automatic finishTest(input string name);
        if (failCount == failsAtStart) begin
            testsPassed++;
            $display("[pass] %s", name);
        end else begin
            testsFailed++;
            $display("[fail] %s, %0d check failures", name, failCount - failsAtStart);
        end
        failsAtStart = failCount;
    endtask

    function automatic logic [`AHB_DATA_W-1:0] ioAddr(input int n);
        return {`IO_REGION, 28'h0} | (32'h40 + 32'(n) * 4);
    endfunction

    // Address phase now with the write data of the previous transfer alongside
    task automatic issueTransfer(input logic wr, input logic [`AHB_DATA_W-1:0] addr,
                                 input logic [`AHB_DATA_W-1:0] data);
        HSEL      = 1'b1;
        HREQUEST  = 1'b1;
        HWRITE    = wr;
        HADDR     = addr;
        HWDATA    = nextWdata;
        nextWdata = data;
        @(posedge HCLK);
        #0.5;
    endtask

    task automatic busIdle(input int cycles);
        HSEL      = 1'b0;
        HREQUEST  = 1'b0;
        HWDATA    = nextWdata;
        nextWdata = '0;
        repeat (cycles) @(posedge HCLK);
        #0.5;
    endtask

    task automatic busWrite(input logic [`AHB_DATA_W-1:0] addr,
                            input logic [`AHB_DATA_W-1:0] data);
        issueTransfer(1'b1, addr, data);
    endtask

    // Back-to-back reads at one per cycle
    task automatic busRead(input logic [`AHB_DATA_W-1:0] addrs [$]);
        foreach (addrs[i]) begin
            issueTransfer(1'b0, addrs[i], '0);
        end
    endtask

    task automatic pushReplay(input logic [`AHB_DATA_W-1:0] addr,
                              input logic [`AHB_DATA_W-1:0] data);
        pushValid = 1'b1;
        pushAddr  = addr;
        pushData  = data;
        @(posedge HCLK);
        #0.5;
        pushValid = 1'b0;
    endtask

    initial begin : watchdog
        #((XFER_COUNT + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        HSEL      = 1'b0;
        HREQUEST  = 1'b0;
        HWRITE    = 1'b0;
        HADDR     = '0;
        HWDATA    = '0;
        pushValid = 1'b0;
        pushAddr  = '0;
        pushData  = '0;
        nextWdata = '0;
        repeat (RESET_CYCLES) @(posedge HCLK);
        #0.5;
        rst = 1'b0;
        busIdle(2);
        finishTest("reset state");

        // Random writes followed by reads straight behind the last write
        addrList = {};
        for (int i = 0; i < RAM_WRITES; i++) begin
            addrList.push_back({`RAM_REGION, 28'h0} |
                               32'(($random(seed) & (`RAM_WORDS - 1)) << 2));
            busWrite(addrList[i], $random(seed));
        end
        addrList.push_back(32'h3000_0010);
        busRead(addrList);
        busIdle(2);
        finishTest("RAM write and read, unmapped read");

        // Fill the queue so that the extra push is dropped
        for (int i = 0; i < `REPLAY_DEPTH; i++) begin
            pushReplay(ioAddr(i), 32'hC0DE_0000 + 32'(i));
        end
        pushReplay(32'h1000_0FF0, 32'h0BAD_0BAD);
        addrList = {};
        for (int i = 0; i < `REPLAY_DEPTH / 2; i++) begin
            addrList.push_back(ioAddr(i));
        end
        busRead(addrList);
        busIdle(2);
        finishTest("replay hits and full flag");

        // A wrong address first, the drain and a read on the empty queue
        addrList = {32'h1000_0FFC};
        for (int i = `REPLAY_DEPTH / 2; i < `REPLAY_DEPTH; i++) begin
            addrList.push_back(ioAddr(i));
        end
        addrList.push_back(ioAddr(0));
        busRead(addrList);
        busIdle(2);
        finishTest("replay miss");

        busWrite(IRQ_ADDR, 32'h1);
        busWrite(IRQ_ADDR, 32'h2);
        busWrite(IRQ_ADDR, 32'h3);
        busWrite(32'h1000_0800, 32'h0);
        busWrite(32'h0000_0400, 32'h0);
        busWrite(IRQ_ADDR, 32'h0);
        busIdle(2);
        finishTest("interrupt register");

        $display("Tests: %0d passed, %0d failed, %0d check failures",
                 testsPassed, testsFailed, failCount);
        if (testsFailed == 0 && failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== ahbIoReplay.f ====
+incdir+hdl
hdl/ahbPkg.sv
hdl/ahbIf.sv
hdl/ahbDecoder.sv
hdl/ahbRam.sv
hdl/ioFwdShim.sv
hdl/ahbSubsys.sv
tests/ahbSubsysTb.sv
